//--- Makefile
TOP := snap_csr_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f snap_csr_top.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log || { echo "simulation did not complete"; exit 1; }

lint:
	verilator --lint-only --timing -Wall --top-module snap_csr_top -f snap_csr_top.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- event_counter.sv
`timescale 1ns/1ps

module event_counter
   import snap_csr_cfg_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 event_in,
   input  logic                 cnt_en,
   input  logic                 load,
   input  logic [CNT_WIDTH-1:0] load_value,
   output logic [CNT_WIDTH-1:0] count,
   output logic                 cnt_step
);

   // a load in the same cycle swallows the event.
   assign cnt_step = event_in & cnt_en & ~load;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         count <= '0;
      else if (load)
         count <= load_value;
      else if (cnt_step)
         count <= count + CNT_WIDTH'(1);   // wraps at full width.
   end

endmodule

//--- reg_access_ctrl.sv
`timescale 1ns/1ps

module reg_access_ctrl
   import snap_csr_cfg_pkg::*;
   import snap_csr_map_pkg::*;
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic [ADDR_WIDTH-1:0]                addr,
   input  logic                                 wr_en,
   input  logic [DATA_WIDTH-1:0]                wr_data,
   input  logic                                 rd_en,
   input  logic [CNT_PARTS-1:0][DATA_WIDTH-1:0] cnt_snap_rd_data,
   input  logic [THR_PARTS-1:0][DATA_WIDTH-1:0] thr_snap_rd_data,
   input  logic                                 pending,
   output logic [CNT_PARTS-1:0]                 cnt_snap_wr_en,
   output logic [CNT_PARTS-1:0]                 cnt_snap_rd_en,
   output logic [THR_PARTS-1:0]                 thr_snap_wr_en,
   output logic [THR_PARTS-1:0]                 thr_snap_rd_en,
   output logic                                 cnt_en,
   output logic                                 pend_clr,
   output logic [DATA_WIDTH-1:0]                rd_data,
   output logic                                 irq
);

   logic [CNT_PARTS-1:0] cnt_sel;
   logic [THR_PARTS-1:0] thr_sel;
   logic                 irq_en;

   // one select bit per word of each wide register.
   assign cnt_sel = {addr == ADDR_CNT_HI, addr == ADDR_CNT_LO};
   assign thr_sel = {addr == ADDR_THR_HI, addr == ADDR_THR_LO};

   assign cnt_snap_wr_en = cnt_sel & {CNT_PARTS{wr_en}};
   assign cnt_snap_rd_en = cnt_sel & {CNT_PARTS{rd_en}};
   assign thr_snap_wr_en = thr_sel & {THR_PARTS{wr_en}};
   assign thr_snap_rd_en = thr_sel & {THR_PARTS{rd_en}};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt_en <= 1'b0;
         irq_en <= 1'b0;
      end else if (wr_en && addr == ADDR_CTRL) begin
         cnt_en <= wr_data[CTRL_CNT_EN_BIT];
         irq_en <= wr_data[CTRL_IRQ_EN_BIT];
      end
   end

   // w1c on the status word.
   assign pend_clr = wr_en && (addr == ADDR_STATUS) && wr_data[STATUS_PEND_BIT];

   assign irq = pending & irq_en;

   always_comb begin
      rd_data = '0;
      if (rd_en) begin
         case (addr)
            ADDR_CNT_LO: rd_data = cnt_snap_rd_data[0];   // live low word.
            ADDR_CNT_HI: rd_data = cnt_snap_rd_data[1];
            ADDR_THR_LO: rd_data = thr_snap_rd_data[0];
            ADDR_THR_HI: rd_data = thr_snap_rd_data[1];
            ADDR_CTRL: begin
               rd_data[CTRL_CNT_EN_BIT] = cnt_en;
               rd_data[CTRL_IRQ_EN_BIT] = irq_en;
            end
            ADDR_STATUS: rd_data[STATUS_PEND_BIT] = pending;
            default: rd_data = '0;   // unmapped.
         endcase
      end
   end

endmodule

//--- snap_csr_cfg_pkg.sv
package snap_csr_cfg_pkg;

   // register bus.
   localparam int DATA_WIDTH = 32;
   localparam int ADDR_WIDTH = 3;   // word address.

   // wide registers behind the bus.
   localparam int CNT_WIDTH = 48;
   localparam int THR_WIDTH = 36;

   // bus words per wide register, rounded up.
   localparam int CNT_PARTS = (CNT_WIDTH + DATA_WIDTH - 1) / DATA_WIDTH;
   localparam int THR_PARTS = (THR_WIDTH + DATA_WIDTH - 1) / DATA_WIDTH;

endpackage

//--- snap_csr_map_pkg.sv
package snap_csr_map_pkg;
   import snap_csr_cfg_pkg::*;

   // word addresses.
   localparam logic [ADDR_WIDTH-1:0] ADDR_CNT_LO = 'd0;
   localparam logic [ADDR_WIDTH-1:0] ADDR_CNT_HI = 'd1;   // reads the snapshot.
   localparam logic [ADDR_WIDTH-1:0] ADDR_THR_LO = 'd2;
   localparam logic [ADDR_WIDTH-1:0] ADDR_THR_HI = 'd3;
   localparam logic [ADDR_WIDTH-1:0] ADDR_CTRL   = 'd4;
   localparam logic [ADDR_WIDTH-1:0] ADDR_STATUS = 'd5;

   // control word.
   localparam int CTRL_CNT_EN_BIT = 0;
   localparam int CTRL_IRQ_EN_BIT = 1;

   // status bits clear on a written one.
   localparam int STATUS_PEND_BIT = 0;

endpackage

//--- snap_csr_properties.sv
`timescale 1ns/1ps

module snap_csr_properties
   import snap_csr_cfg_pkg::*;
(
   input logic                 clk,
   input logic                 rst_n,
   input logic                 irq,
   input logic                 pending,
   input logic                 cnt_load,
   input logic [CNT_WIDTH-1:0] count,
   input logic [CNT_PARTS-1:0] cnt_snap_wr_en,
   input logic [CNT_PARTS-1:0] cnt_snap_rd_en,
   input logic [THR_PARTS-1:0] thr_snap_wr_en,
   input logic [THR_PARTS-1:0] thr_snap_rd_en
);

   irq_needs_pending: assert property (@(posedge clk) disable iff (!rst_n) irq |-> pending)
      else $error("irq high while pending is low");

   // count holds, steps by one, or was loaded.
   count_moves_by_one: assert property (@(posedge clk) disable iff (!rst_n)
      $past(cnt_load) || count == $past(count) || count == $past(count) + CNT_WIDTH'(1))
      else $error("count jumped without a load");

   snap_strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !((|cnt_snap_wr_en) && (|cnt_snap_rd_en)) && !((|thr_snap_wr_en) && (|thr_snap_rd_en)))
      else $error("snapshot read and write strobes high together");

endmodule

bind snap_csr_top snap_csr_properties props0 (
   .clk, .rst_n, .irq, .pending, .cnt_load, .count,
   .cnt_snap_wr_en, .cnt_snap_rd_en, .thr_snap_wr_en, .thr_snap_rd_en
);

//--- snap_csr_tb.sv
`timescale 1ns/1ps

module snap_csr_tb
   import snap_csr_cfg_pkg::*;
   import snap_csr_map_pkg::*;
();

   localparam int HALF_PERIOD = 20;
   localparam int RAND_BURSTS = 24;
   // directed part stays under 150 cycles, one burst under 30.
   localparam int MAX_CYCLES  = 2 * (150 + RAND_BURSTS * 30);

   logic                  clk;
   logic                  rst_n;
   logic [ADDR_WIDTH-1:0] addr;
   logic                  wr_en;
   logic [DATA_WIDTH-1:0] wr_data;
   logic                  rd_en;
   logic [DATA_WIDTH-1:0] rd_data;
   logic                  event_in;
   logic                  irq;

   int                    errors;
   int                    checks;
   int                    cycles;
   logic [31:0]           seed;
   logic [CNT_WIDTH-1:0]  model_count;
   logic [THR_WIDTH-1:0]  model_thr;
   logic                  model_pend;

   snap_csr_top dut0 (
      .clk, .rst_n, .addr, .wr_en, .wr_data, .rd_en, .rd_data, .event_in, .irq
   );

   always #(HALF_PERIOD) clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout after %0d cycles, the tests did not finish", cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   function automatic logic [31:0] next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp);
      checks++;
      assert (got === exp)
      else begin
         errors++;
         $display("FAIL %0t ns %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
      end
   endtask

   // all bus tasks start and end 1 ns after a rising edge.
   task automatic bus_write(input logic [ADDR_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] d);
      addr    = a;
      wr_data = d;
      wr_en   = 1'b1;
      @(posedge clk);
      #1;
      wr_en = 1'b0;
   endtask

   task automatic bus_read_check(input logic [ADDR_WIDTH-1:0] a,
                                 input logic [DATA_WIDTH-1:0] exp, input string name);
      addr  = a;
      rd_en = 1'b1;
      @(negedge clk);   // rd_data settled.
      check_value(name, rd_data, exp);
      @(posedge clk);
      #1;
      rd_en = 1'b0;
   endtask

   task automatic pulse_events(input int n);
      event_in = 1'b1;
      repeat (n) begin
         @(posedge clk);
         #1;
      end
      event_in = 1'b0;
   endtask

   task automatic advance_model(input int n);
      for (int i = 0; i < n; i++) begin
         model_count = model_count + 1'b1;
         if (model_count == CNT_WIDTH'(model_thr))
            model_pend = 1'b1;
      end
   endtask

   task automatic write_count(input logic [CNT_WIDTH-1:0] v);
      bus_write(ADDR_CNT_HI, DATA_WIDTH'(v[CNT_WIDTH-1:DATA_WIDTH]));
      bus_write(ADDR_CNT_LO, v[DATA_WIDTH-1:0]);
   endtask

   task automatic write_threshold(input logic [THR_WIDTH-1:0] v);
      bus_write(ADDR_THR_HI, DATA_WIDTH'(v[THR_WIDTH-1:DATA_WIDTH]));
      bus_write(ADDR_THR_LO, v[DATA_WIDTH-1:0]);
      model_thr = v;
   endtask

   // low word first so the upper word comes from the same capture.
   task automatic check_count();
      bus_read_check(ADDR_CNT_LO, model_count[DATA_WIDTH-1:0], "cnt_lo");
      bus_read_check(ADDR_CNT_HI, DATA_WIDTH'(model_count[CNT_WIDTH-1:DATA_WIDTH]), "cnt_hi");
   endtask

   task automatic reset_values();
      check_value("irq", DATA_WIDTH'(irq), '0);
      for (int a = 0; a < 8; a++)
         bus_read_check(ADDR_WIDTH'(a), '0, "rd_data after reset");
   endtask

   task automatic counter_load();
      logic [31:0] r_hi;
      logic [31:0] r_lo;
      r_hi = next_rand();
      r_lo = next_rand();
      model_count = {r_hi[15:0], r_lo};
      write_count(model_count);
      check_count();
      pulse_events(3);   // counter disabled.
      check_count();
      bus_write(ADDR_CTRL, 32'h1);
      bus_read_check(ADDR_CTRL, 32'h1, "ctrl");
      pulse_events(3);
      advance_model(3);
      check_count();
      bus_write(ADDR_CTRL, 32'h0);
   endtask

   task automatic snapshot_coherence();
      model_count = 48'h0000_FFFF_FFFF;
      write_count(model_count);
      bus_write(ADDR_CTRL, 32'h1);
      bus_read_check(ADDR_CNT_LO, 32'hFFFF_FFFF, "cnt_lo before event");
      pulse_events(1);
      advance_model(1);
      bus_read_check(ADDR_CNT_HI, 32'h0, "cnt_hi from old capture");
      check_count();
      bus_write(ADDR_CTRL, 32'h0);
   endtask

   task automatic threshold_mask();
      write_threshold('1);
      bus_write(ADDR_THR_HI, 32'hFFFF_FFFF);
      bus_write(ADDR_THR_LO, 32'hFFFF_FFFF);
      bus_read_check(ADDR_THR_LO, 32'hFFFF_FFFF, "thr_lo");
      bus_read_check(ADDR_THR_HI, (32'h1 << (THR_WIDTH - DATA_WIDTH)) - 1, "thr_hi");
   endtask

   task automatic interrupt_flow();
      write_threshold(36'd20);
      model_count = 48'd17;
      write_count(model_count);
      bus_write(ADDR_CTRL, 32'h1);   // count on, irq off.
      for (int i = 0; i < 3; i++) begin
         pulse_events(1);
         advance_model(1);
         bus_read_check(ADDR_STATUS, DATA_WIDTH'(model_pend), "status");
      end
      bus_read_check(ADDR_STATUS, 32'h1, "status at threshold");
      check_value("irq", DATA_WIDTH'(irq), 32'h0);
      bus_write(ADDR_CTRL, 32'h3);
      check_value("irq", DATA_WIDTH'(irq), 32'h1);
      bus_write(ADDR_CTRL, 32'h1);
      check_value("irq", DATA_WIDTH'(irq), 32'h0);
      bus_write(ADDR_CTRL, 32'h3);
      bus_write(ADDR_STATUS, 32'h1);
      model_pend = 1'b0;
      bus_read_check(ADDR_STATUS, 32'h0, "status after clear");
      check_value("irq", DATA_WIDTH'(irq), 32'h0);
   endtask

   task automatic random_bursts();
      logic [31:0] r;
      logic        en;
      int          len;
      write_threshold(36'd30);
      model_count = '0;
      write_count(model_count);
      for (int b = 0; b < RAND_BURSTS; b++) begin
         r   = next_rand();
         en  = r[20];
         len = int'(r[26:24]) + 1;
         bus_write(ADDR_CTRL, {30'b0, 1'b1, en});
         pulse_events(len);
         if (en)
            advance_model(len);
         check_count();
         bus_read_check(ADDR_STATUS, DATA_WIDTH'(model_pend), "status");
         check_value("irq", DATA_WIDTH'(irq), DATA_WIDTH'(model_pend));
         if (model_pend) begin
            bus_write(ADDR_STATUS, 32'h1);
            model_pend = 1'b0;
         end
      end
   endtask

   initial begin
      clk         = 1'b0;
      rst_n       = 1'b0;
      addr        = '0;
      wr_en       = 1'b0;
      wr_data     = '0;
      rd_en       = 1'b0;
      event_in    = 1'b0;
      errors      = 0;
      checks      = 0;
      cycles      = 0;
      seed        = 32'h469e_86f6;
      model_count = '0;
      model_thr   = '0;
      model_pend  = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      reset_values();
      counter_load();
      snapshot_coherence();
      threshold_mask();
      interrupt_flow();
      random_bursts();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- snap_csr_top.f
snap_csr_cfg_pkg.sv
snap_csr_map_pkg.sv
reg_access_ctrl.sv
snapshot_reg.sv
event_counter.sv
threshold_match.sv
snap_csr_top.sv
snap_csr_properties.sv
snap_csr_tb.sv

//--- snap_csr_top.sv
`timescale 1ns/1ps

module snap_csr_top
   import snap_csr_cfg_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [ADDR_WIDTH-1:0] addr,
   input  logic                  wr_en,
   input  logic [DATA_WIDTH-1:0] wr_data,
   input  logic                  rd_en,
   output logic [DATA_WIDTH-1:0] rd_data,
   input  logic                  event_in,
   output logic                  irq
);

   logic [CNT_PARTS-1:0]                 cnt_snap_wr_en;
   logic [CNT_PARTS-1:0]                 cnt_snap_rd_en;
   logic [THR_PARTS-1:0]                 thr_snap_wr_en;
   logic [THR_PARTS-1:0]                 thr_snap_rd_en;
   logic [CNT_PARTS-1:0][DATA_WIDTH-1:0] cnt_snap_rd_data;
   logic [THR_PARTS-1:0][DATA_WIDTH-1:0] thr_snap_rd_data;
   logic                                 cnt_load;
   logic [CNT_WIDTH-1:0]                 cnt_load_value;
   logic                                 thr_load;
   logic [THR_WIDTH-1:0]                 thr_load_value;
   logic [CNT_WIDTH-1:0]                 count;
   logic [THR_WIDTH-1:0]                 threshold;
   logic                                 cnt_step;
   logic                                 cnt_en;
   logic                                 pend_clr;
   logic                                 pending;

   reg_access_ctrl ctrl0 (
      .clk, .rst_n, .addr, .wr_en, .wr_data, .rd_en,
      .cnt_snap_rd_data, .thr_snap_rd_data, .pending,
      .cnt_snap_wr_en, .cnt_snap_rd_en, .thr_snap_wr_en, .thr_snap_rd_en,
      .cnt_en, .pend_clr, .rd_data, .irq
   );

   snapshot_reg #(.REG_WIDTH(CNT_WIDTH), .PART_CNT(CNT_PARTS)) cnt_snap (
      .clk, .rst_n,
      .snap_wr_en(cnt_snap_wr_en), .snap_rd_en(cnt_snap_rd_en),
      .snap_wr_data(wr_data), .reg_rd_data(count), .snap_rd_data(cnt_snap_rd_data),
      .reg_wr_en(cnt_load), .reg_wr_data(cnt_load_value)
   );

   snapshot_reg #(.REG_WIDTH(THR_WIDTH), .PART_CNT(THR_PARTS)) thr_snap (
      .clk, .rst_n,
      .snap_wr_en(thr_snap_wr_en), .snap_rd_en(thr_snap_rd_en),
      .snap_wr_data(wr_data), .reg_rd_data(threshold), .snap_rd_data(thr_snap_rd_data),
      .reg_wr_en(thr_load), .reg_wr_data(thr_load_value)
   );

   event_counter counter0 (
      .clk, .rst_n, .event_in, .cnt_en,
      .load(cnt_load), .load_value(cnt_load_value), .count, .cnt_step
   );

   threshold_match match0 (
      .clk, .rst_n, .load(thr_load), .load_value(thr_load_value),
      .count, .cnt_step, .pend_clr, .threshold, .pending
   );

endmodule

//--- snapshot_reg.sv
`timescale 1ns/1ps

module snapshot_reg
   import snap_csr_cfg_pkg::*;
#(
   parameter int REG_WIDTH = CNT_WIDTH,
   parameter int PART_CNT  = CNT_PARTS
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic [PART_CNT-1:0]                 snap_wr_en,
   input  logic [PART_CNT-1:0]                 snap_rd_en,
   input  logic [DATA_WIDTH-1:0]               snap_wr_data,
   input  logic [REG_WIDTH-1:0]                reg_rd_data,
   output logic [PART_CNT-1:0][DATA_WIDTH-1:0] snap_rd_data,
   output logic                                reg_wr_en,
   output logic [REG_WIDTH-1:0]                reg_wr_data
);

   localparam int PAD_WIDTH = PART_CNT * DATA_WIDTH;

   logic [REG_WIDTH-1:0] snapshot;
   logic [PAD_WIDTH-1:0] snap_pad;
   logic [PAD_WIDTH-1:0] snap_next;

   assign snap_pad = PAD_WIDTH'(snapshot);   // zero above the register.

   // bus word lands in its partition; bits past REG_WIDTH fall off below.
   always_comb begin
      snap_next = snap_pad;
      for (int i = 0; i < PART_CNT; i++) begin
         if (snap_wr_en[i])
            snap_next[i*DATA_WIDTH +: DATA_WIDTH] = snap_wr_data;
      end
   end

   // a low-word read freezes the whole register for the upper reads.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         snapshot <= '0;
      else if (snap_rd_en[0])
         snapshot <= reg_rd_data;
      else if (|snap_wr_en)
         snapshot <= snap_next[REG_WIDTH-1:0];
   end

   always_comb begin
      snap_rd_data = '0;
      if (snap_rd_en[0])
         snap_rd_data[0] = reg_rd_data[DATA_WIDTH-1:0];   // live, not captured.
      for (int i = 1; i < PART_CNT; i++) begin
         if (snap_rd_en[i])
            snap_rd_data[i] = snap_pad[i*DATA_WIDTH +: DATA_WIDTH];
      end
   end

   // low-word write commits the staged upper bits.
   assign reg_wr_en   = snap_wr_en[0];
   assign reg_wr_data = {snapshot[REG_WIDTH-1:DATA_WIDTH], snap_wr_data};

endmodule

//--- threshold_match.sv
`timescale 1ns/1ps

module threshold_match
   import snap_csr_cfg_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 load,
   input  logic [THR_WIDTH-1:0] load_value,
   input  logic [CNT_WIDTH-1:0] count,
   input  logic                 cnt_step,
   input  logic                 pend_clr,
   output logic [THR_WIDTH-1:0] threshold,
   output logic                 pending
);

   logic [CNT_WIDTH-1:0] count_next;
   logic                 hit;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         threshold <= '0;
      else if (load)
         threshold <= load_value;
   end

   // compare against the value the step is about to write.
   assign count_next = count + CNT_WIDTH'(1);
   assign hit        = cnt_step && (count_next == CNT_WIDTH'(threshold));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         pending <= 1'b0;
      else if (hit)
         pending <= 1'b1;   // set beats clear.
      else if (pend_clr)
         pending <= 1'b0;
   end

endmodule
